// ==== exec_trace.txt ====
// op dst src imm expected, op 0 nop 1 mov_imm 2-6 add sub and or xor 7 add_imm 8 rep_dec f end
// expected is the written value, or the starting ECX count for rep_dec
2 0 2 00000000 00000000
1 3 0 fffffff0 fffffff0
1 2 0 00000025 00000025
2 3 2 00000000 00000015
3 3 2 00000000 fffffff0
4 3 2 00000000 00000020
5 3 2 00000000 00000025
6 3 2 00000000 00000000
7 3 0 7fffffff 7fffffff
7 3 0 00000002 80000001
1 1 0 00000004 00000004
8 1 1 00000000 00000004
7 6 0 00000005 00000005
2 6 2 00000000 0000002a
1 7 0 12345678 12345678
6 1 2 00000000 00000025
1 1 0 00000000 00000000
8 1 1 00000000 00000000
7 1 0 00000003 00000003
0 0 0 00000000 00000000
8 1 1 00000000 00000003
2 2 2 00000000 0000004a
1 1 0 00000009 00000009
5 0 1 00000000 00000009
f 0 0 00000000 00000000

// ==== flist.f ====
x86_arch_pkg.sv
exec_pkg.sv
wb_if.sv
reg_file.sv
issue_alu.sv
rep_counter.sv
wb_arbiter.sv
exec_slice_top.sv
tb_clk_gen.sv
tb_checker.sv
tb_exec_slice.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the execute slice testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_exec_slice -f flist.f -o sim_exec
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_exec > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qF "*** TEST FAILED ***" "$LOG"; then
   exit 1
fi
exit 0

// ==== tb_exec_slice.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_exec_slice;

   localparam int MAX_OPS = 64;
   localparam int DRIVE_DLY = 2;

   logic                   clk;
   logic                   rst_n;
   logic                   op_valid;
   exec_pkg::op_e          op_code;
   x86_arch_pkg::reg_idx_t op_dst;
   x86_arch_pkg::reg_idx_t op_src;
   x86_arch_pkg::imm_t     op_imm;
   logic                   op_ready;
   logic                   wb_valid;
   x86_arch_pkg::reg_idx_t wb_reg;
   x86_arch_pkg::word_t    wb_data;
   logic                   done;
   int                     value_errs;
   int                     other_errs;
   int                     ops_accepted;
   int                     writes_left;

   logic [31:0] trace_mem [5*MAX_OPS];
   int     n_ops = 0;
   int     cycle_limit = 0;
   int     cycles = 0;
   integer seed;

   tb_clk_gen u_clk_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   exec_slice_top u_exec_slice_top (
      .clk      (clk),
      .rst_n    (rst_n),
      .op_valid (op_valid),
      .op_code  (op_code),
      .op_dst   (op_dst),
      .op_src   (op_src),
      .op_imm   (op_imm),
      .op_ready (op_ready),
      .wb_valid (wb_valid),
      .wb_reg   (wb_reg),
      .wb_data  (wb_data)
   );

   tb_checker u_checker (
      .clk          (clk),
      .rst_n        (rst_n),
      .op_valid     (op_valid),
      .op_ready     (op_ready),
      .wb_valid     (wb_valid),
      .wb_reg       (wb_reg),
      .wb_data      (wb_data),
      .done         (done),
      .value_errs   (value_errs),
      .other_errs   (other_errs),
      .ops_accepted (ops_accepted),
      .writes_left  (writes_left)
   );

   // Presents trace entry i and holds it until op_ready at an edge
   task automatic send_op(input int i);
      logic took;
      op_valid = 1'b1;
      op_code  = exec_pkg::op_e'(trace_mem[5*i][3:0]);
      op_dst   = trace_mem[5*i+1][2:0];
      op_src   = trace_mem[5*i+2][2:0];
      op_imm   = trace_mem[5*i+3];
      took     = 1'b0;
      while (!took) begin
         @(negedge clk);
         took = op_ready;
         @(posedge clk);
         #DRIVE_DLY;
      end
      op_valid = 1'b0;
   endtask

   initial begin
      int rep_sum;
      int r;
      int gap;
      seed     = 32'h146f5141;
      op_valid = 1'b0;
      op_code  = exec_pkg::OP_NOP;
      op_dst   = '0;
      op_src   = '0;
      op_imm   = '0;
      rep_sum  = 0;
      $readmemh("exec_trace.txt", trace_mem);
      while (n_ops < MAX_OPS && trace_mem[5*n_ops] != 32'hf) begin
         if (trace_mem[5*n_ops] == 32'h8) begin
            rep_sum += trace_mem[5*n_ops+4];
         end
         n_ops++;
      end
      cycle_limit = 4 * (n_ops + rep_sum) + 100;

      @(posedge rst_n);
      @(posedge clk);
      #DRIVE_DLY;
      for (int i = 0; i < n_ops; i++) begin
         r   = $random(seed);
         gap = r[2] ? 0 : {30'd0, r[1:0]}; // Idle cycles about half the time
         repeat (gap) begin
            @(posedge clk);
            #DRIVE_DLY;
         end
         send_op(i);
      end

      wait (done);
      repeat (4) @(posedge clk); // Room for a stray write to show
      $display("Errors: %0d value mismatches, %0d other failures, 0 timeouts",
               value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("Timeout after %0d cycles: %0d of %0d operations accepted, %0d writes missing",
                  cycles, ops_accepted, n_ops, writes_left);
         $display("Errors: %0d value mismatches, %0d other failures, 1 timeouts",
                  value_errs, other_errs);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_checker (
   input  wire                         clk,
   input  wire                         rst_n,
   input  wire                         op_valid,
   input  wire                         op_ready,
   input  wire                         wb_valid,
   input  wire x86_arch_pkg::reg_idx_t wb_reg,
   input  wire x86_arch_pkg::word_t    wb_data,
   output logic                        done,
   output int                          value_errs,
   output int                          other_errs,
   output int                          ops_accepted,
   output int                          writes_left
);

   localparam int MAX_OPS = 64;

   logic [31:0] trace_mem [5*MAX_OPS];
   x86_arch_pkg::reg_idx_t alu_reg_q [$];
   x86_arch_pkg::word_t    alu_val_q [$];
   x86_arch_pkg::word_t    rep_val_q [$]; // Countdown values still owed
   int   n_ops = 0;
   int   n_acc = 0;
   int   alu_owed = 0; // Accepted ALU ops not yet written back
   int   n_val = 0;
   int   n_other = 0;
   int   n_left = 0;
   logic all_seen = 1'b0;

   assign done         = all_seen;
   assign value_errs   = n_val;
   assign other_errs   = n_other;
   assign ops_accepted = n_acc;
   assign writes_left  = n_left;

   initial begin
      $readmemh("exec_trace.txt", trace_mem);
      while (n_ops < MAX_OPS && trace_mem[5*n_ops] != 32'hf) begin
         if (trace_mem[5*n_ops] >= 32'h1 && trace_mem[5*n_ops] <= 32'h7) begin
            alu_reg_q.push_back(trace_mem[5*n_ops+1][2:0]);
            alu_val_q.push_back(trace_mem[5*n_ops+4]);
         end
         n_ops++;
      end
   end

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      if (act !== exp) begin
         $display("FAIL at %0t: %s expected %h, actual %h", $time, name, exp, act);
         n_val++;
      end
   endtask

   task automatic score_write();
      if (rep_val_q.size() > 0 && wb_reg == x86_arch_pkg::REG_ECX) begin
         check_value("wb_data", rep_val_q.pop_front(), wb_data); // Counter owns ECX now
      end else if (alu_owed == 0) begin
         $display("%0t: unexpected write of %h to register %0d", $time, wb_data, wb_reg);
         n_other++;
      end else begin
         check_value("wb_reg", 32'(alu_reg_q.pop_front()), 32'(wb_reg));
         check_value("wb_data", alu_val_q.pop_front(), wb_data);
         alu_owed--;
      end
   endtask

   task automatic note_accept();
      logic [31:0] t_op;
      logic [31:0] cnt;
      if (n_acc >= n_ops) begin
         $display("%0t: an operation was accepted beyond the end of the trace", $time);
         n_other++;
      end else begin
         t_op = trace_mem[5*n_acc];
         cnt  = trace_mem[5*n_acc+4];
         if (t_op == 32'h8) begin
            while (cnt != 32'd0) begin
               cnt = cnt - 32'd1;
               rep_val_q.push_back(cnt); // n-1 down to 0
            end
         end else if (t_op != 32'h0) begin
            alu_owed++;
         end
         n_acc++;
      end
   endtask

   // Sampled mid-cycle where DUT outputs have settled
   always @(negedge clk) begin
      if (!rst_n) begin
         if (wb_valid || op_ready) begin
            $display("%0t: wb_valid or op_ready was high during reset", $time);
            n_other++;
         end
      end else begin
         if (wb_valid) begin
            score_write();
         end
         if (op_valid && op_ready) begin
            note_accept();
         end
      end
      n_left   = alu_reg_q.size() + rep_val_q.size();
      all_seen = (n_ops > 0) && (n_acc == n_ops) && (n_left == 0);
   end

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
   output logic clk,
   output logic rst_n
);

   localparam int HALF_PERIOD = 10; // 20 ns clock

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // Two cycles of reset, released just after an edge
   initial begin
      rst_n = 1'b0;
      repeat (2) @(posedge clk);
      #2;
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// ==== exec_slice_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_slice_top (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire                     op_valid,
   input  wire exec_pkg::op_e      op_code,
   input  wire x86_arch_pkg::reg_idx_t op_dst,
   input  wire x86_arch_pkg::reg_idx_t op_src,
   input  wire x86_arch_pkg::imm_t     op_imm,
   output logic                    op_ready,
   output logic                    wb_valid,
   output x86_arch_pkg::reg_idx_t  wb_reg,
   output x86_arch_pkg::word_t     wb_data
);

   x86_arch_pkg::reg_idx_t rd_a_idx;
   x86_arch_pkg::reg_idx_t rd_b_idx;
   x86_arch_pkg::word_t    rd_a_data;
   x86_arch_pkg::word_t    rd_b_data;
   x86_arch_pkg::word_t    ecx;
   x86_arch_pkg::word_t    rep_count;
   logic                   rep_start;
   logic                   rep_busy;

   wb_if wb_alu ();
   wb_if wb_rep ();

   // Arbiter output is also the register write port
   reg_file u_reg_file (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_a_idx  (rd_a_idx),
      .rd_b_idx  (rd_b_idx),
      .we        (wb_valid),
      .wr_idx    (wb_reg),
      .wr_data   (wb_data),
      .rd_a_data (rd_a_data),
      .rd_b_data (rd_b_data),
      .ecx       (ecx)
   );

   issue_alu u_issue_alu (
      .clk       (clk),
      .rst_n     (rst_n),
      .op_valid  (op_valid),
      .op_code   (op_code),
      .op_dst    (op_dst),
      .op_src    (op_src),
      .op_imm    (op_imm),
      .rd_a_data (rd_a_data),
      .rd_b_data (rd_b_data),
      .ecx       (ecx),
      .rep_busy  (rep_busy),
      .op_ready  (op_ready),
      .rd_a_idx  (rd_a_idx),
      .rd_b_idx  (rd_b_idx),
      .rep_start (rep_start),
      .rep_count (rep_count),
      .wb        (wb_alu.src)
   );

   rep_counter u_rep_counter (
      .clk       (clk),
      .rst_n     (rst_n),
      .rep_start (rep_start),
      .rep_count (rep_count),
      .rep_busy  (rep_busy),
      .wb        (wb_rep.src)
   );

   wb_arbiter u_wb_arbiter (
      .wb_rep    (wb_rep.arb),
      .wb_alu    (wb_alu.arb),
      .wb_valid  (wb_valid),
      .wb_reg    (wb_reg),
      .wb_data   (wb_data)
   );

endmodule

`default_nettype wire

// ==== wb_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_arbiter (
   wb_if.arb                       wb_rep,
   wb_if.arb                       wb_alu,
   output logic                    wb_valid,
   output x86_arch_pkg::reg_idx_t  wb_reg,
   output x86_arch_pkg::word_t     wb_data
);

   // Counter has priority over the ALU
   assign wb_rep.gnt = wb_rep.req;
   assign wb_alu.gnt = wb_alu.req && !wb_rep.req;

   assign wb_valid = wb_rep.gnt || wb_alu.gnt;

   always_comb begin
      wb_reg  = '0;
      wb_data = '0;
      if (wb_rep.gnt) begin
         wb_reg  = wb_rep.idx;
         wb_data = wb_rep.data;
      end else if (wb_alu.gnt) begin
         wb_reg  = wb_alu.idx;
         wb_data = wb_alu.data;
      end
   end

endmodule

`default_nettype wire

// ==== rep_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module rep_counter (
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire                  rep_start,
   input  wire x86_arch_pkg::word_t rep_count,
   output logic                 rep_busy,
   wb_if.src                    wb
);

   x86_arch_pkg::word_t count_q;
   x86_arch_pkg::word_t count_dec;
   logic active;

   assign active    = (count_q != '0);
   assign count_dec = count_q - x86_arch_pkg::word_t'(1);

   // Zero count loads zero and never requests
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count_q <= '0;
      end else if (rep_start) begin
         count_q <= rep_count;
      end else if (wb.gnt) begin
         count_q <= count_dec; // One step per granted write
      end
   end

   assign rep_busy = active;

   // Next ECX value, stable until granted
   assign wb.req  = active;
   assign wb.idx  = x86_arch_pkg::REG_ECX;
   assign wb.data = count_dec;

   // Issue side must hold REP and ECX users while counting
   a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
      rep_start |-> !rep_busy);

   // Grant only ever lands on an active countdown
   a_gnt_active: assert property (@(posedge clk) disable iff (!rst_n)
      wb.gnt |-> active);

endmodule

`default_nettype wire

// ==== issue_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_alu (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire                     op_valid,
   input  wire exec_pkg::op_e      op_code,
   input  wire x86_arch_pkg::reg_idx_t op_dst,
   input  wire x86_arch_pkg::reg_idx_t op_src,
   input  wire x86_arch_pkg::imm_t     op_imm,
   input  wire x86_arch_pkg::word_t    rd_a_data,
   input  wire x86_arch_pkg::word_t    rd_b_data,
   input  wire x86_arch_pkg::word_t    ecx,
   input  wire                     rep_busy,
   output logic                    op_ready,
   output x86_arch_pkg::reg_idx_t  rd_a_idx,
   output x86_arch_pkg::reg_idx_t  rd_b_idx,
   output logic                    rep_start,
   output x86_arch_pkg::word_t     rep_count,
   wb_if.src                       wb
);

   logic run_q;
   logic fire;
   logic writes_reg;
   logic names_ecx;
   logic stall_full;
   logic stall_rep;
   logic req_q;
   x86_arch_pkg::word_t result;
   x86_arch_pkg::reg_idx_t idx_q;
   x86_arch_pkg::word_t data_q;

   assign rd_a_idx = op_dst; // dst is also the left operand
   assign rd_b_idx = op_src;

   assign names_ecx = (op_dst == x86_arch_pkg::REG_ECX) ||
                      (op_src == x86_arch_pkg::REG_ECX);

   // Keep off ECX while a countdown owns it
   assign stall_rep  = rep_busy && ((op_code == exec_pkg::OP_REP_DEC) || names_ecx);
   assign stall_full = req_q && !wb.gnt;
   assign op_ready   = run_q && !stall_full && !stall_rep;
   assign fire       = op_valid && op_ready;

   assign rep_start = fire && (op_code == exec_pkg::OP_REP_DEC);
   assign rep_count = ecx;

   always_comb begin
      writes_reg = 1'b1;
      result     = '0;
      case (op_code)
         exec_pkg::OP_MOV_IMM: result = op_imm;
         exec_pkg::OP_ADD:     result = rd_a_data + rd_b_data;
         exec_pkg::OP_SUB:     result = rd_a_data - rd_b_data;
         exec_pkg::OP_AND:     result = rd_a_data & rd_b_data;
         exec_pkg::OP_OR:      result = rd_a_data | rd_b_data;
         exec_pkg::OP_XOR:     result = rd_a_data ^ rd_b_data;
         exec_pkg::OP_ADD_IMM: result = rd_a_data + op_imm;
         default:              writes_reg = 1'b0; // NOP, REP_DEC
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         run_q <= 1'b0;
         req_q <= 1'b0;
      end else begin
         run_q <= 1'b1;
         if (wb.gnt) begin
            req_q <= 1'b0;
         end
         if (fire && writes_reg) begin
            req_q <= 1'b1; // Overrides the drain on a back-to-back
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fire && writes_reg) begin
         idx_q  <= op_dst;
         data_q <= result;
      end
   end

   assign wb.req  = req_q;
   assign wb.idx  = idx_q;
   assign wb.data = data_q;

   // Result held until the arbiter takes it
   a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      wb.req && !wb.gnt |=> wb.req && $stable(wb.idx) && $stable(wb.data));

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire x86_arch_pkg::reg_idx_t rd_a_idx,
   input  wire x86_arch_pkg::reg_idx_t rd_b_idx,
   input  wire                     we,
   input  wire x86_arch_pkg::reg_idx_t wr_idx,
   input  wire x86_arch_pkg::word_t    wr_data,
   output x86_arch_pkg::word_t     rd_a_data,
   output x86_arch_pkg::word_t     rd_b_data,
   output x86_arch_pkg::word_t     ecx
);

   x86_arch_pkg::word_t regs [x86_arch_pkg::NUM_REGS];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < x86_arch_pkg::NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[wr_idx] <= wr_data;
      end
   end

   // Write-through so a same-cycle reader sees the new value
   assign rd_a_data = (we && (wr_idx == rd_a_idx)) ? wr_data : regs[rd_a_idx];
   assign rd_b_data = (we && (wr_idx == rd_b_idx)) ? wr_data : regs[rd_b_idx];

   assign ecx = (we && (wr_idx == x86_arch_pkg::REG_ECX)) ? wr_data
                                                           : regs[x86_arch_pkg::REG_ECX];

endmodule

`default_nettype wire

// ==== wb_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface wb_if;

   logic req;
   logic gnt;  // Combinational, from the arbiter
   x86_arch_pkg::reg_idx_t idx;
   x86_arch_pkg::word_t data;

   modport src (
      output req,
      output idx,
      output data,
      input  gnt
   );

   modport arb (
      input  req,
      input  idx,
      input  data,
      output gnt
   );

endinterface

`default_nettype wire

// ==== exec_pkg.sv ====
`default_nettype none

package exec_pkg;

   localparam int OPCODE_W = 4;

   // Integer slice operations
   typedef enum logic [OPCODE_W-1:0] {
      OP_NOP     = 4'h0,
      OP_MOV_IMM = 4'h1, // dst = imm
      OP_ADD     = 4'h2,
      OP_SUB     = 4'h3,
      OP_AND     = 4'h4,
      OP_OR      = 4'h5,
      OP_XOR     = 4'h6,
      OP_ADD_IMM = 4'h7, // dst = dst + imm
      OP_REP_DEC = 4'h8  // Countdown on ECX
   } op_e;

endpackage

`default_nettype wire

// ==== x86_arch_pkg.sv ====
`default_nettype none

package x86_arch_pkg;

   // General register file geometry
   localparam int WORD_W = 32;
   localparam int NUM_REGS = 8;
   localparam int REG_IDX_W = $clog2(NUM_REGS);

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   // Immediates are sign-extended to full width before they get here
   typedef word_t imm_t;

   localparam reg_idx_t REG_ECX = 3'd1; // Count register for REP

endpackage

`default_nettype wire
